// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
    import core_pkg::*;
(
    input  opcode_t             opc,
    input  logic [reg_size-1:0] a,
    input  logic [reg_size-1:0] b,
    output logic [reg_size-1:0] result,
    output logic                nonzero
);

    localparam int shift_w = $clog2(reg_size);

    always_comb
    begin
        case (opc)
            op_add:
                result = a + b;
            op_sub:
                result = a - b;
            op_mul:
                result = a * b;  // low byte only
            op_cmpge:
                result = {{(reg_size-1){1'b0}}, a >= b};
            op_rshift:
                result = a >> b[shift_w-1:0];
            op_lshift:
                result = a << b[shift_w-1:0];
            op_and:
                result = a & b;
            op_or:
                result = a | b;
            op_xor:
                result = a ^ b;
            default:
                result = '0;
        endcase
    end

    assign nonzero = |a;  // bnz condition on src_0

endmodule

`default_nettype wire

// ==== core.sv ====
`timescale 1ns/1ps
`default_nettype none

module core
    import core_pkg::*;
#(
    parameter int core_id    = 0,
    parameter int insn_count = 16
)(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            init_r0_flag,
    input  logic [reg_size-1:0]             init_r0_data,
    input  logic [insn_count*insn_size-1:0] insn_data,
    output logic                            ready,
    output mem_req_t                        mem_req,
    input  mem_rsp_t                        mem_rsp
);

    insn_t fd, dx, xm, mw;  // stage registers
    insn_t fetched;
    logic [insn_ptr_size-1:0] pc;
    logic [reg_size-1:0] dx_a, dx_b, dx_c;
    logic [reg_size-1:0] xm_o, xm_b, xm_c;
    logic [reg_size-1:0] mw_o, mw_d;
    logic [reg_size-1:0] rd_0, rd_1, rd_2;
    logic [reg_size-1:0] a_fwd, b_fwd, c_fwd, m_c;
    logic [reg_size-1:0] alu_result, x_o, w_result;
    logic nonzero, taken, stall, freeze, hold, fetch_stop;
    logic fd_reads_a, fd_reads_ab, xm_fwd, accept;

    assign accept = start && ready;

    register_file register_file_i (
        .clk(clk),
        .reset(reset),
        .init_r0(accept && init_r0_flag),
        .init_r0_data(init_r0_data),
        .src_0(fd.src_0),
        .src_1(fd.src_1),
        .src_2(fd.src_2),
        .rd_0(rd_0),
        .rd_1(rd_1),
        .rd_2(rd_2),
        .wr_en(writes_reg(mw)),
        .wr_addr(insn_dst(mw)),
        .wr_data(w_result)
    );

    insn_memory #(.insn_count(insn_count)) insn_memory_i (
        .clk(clk),
        .load(accept),
        .insn_data(insn_data),
        .ptr(pc),
        .insn(fetched)
    );

    alu alu_i (
        .opc(dx.opc),
        .a(a_fwd),
        .b(b_fwd),
        .result(alu_result),
        .nonzero(nonzero)
    );

    assign xm_fwd   = writes_reg(xm) && xm.opc != op_ld;  // load data not back yet
    assign w_result = (mw.opc == op_ld) ? mw_d : mw_o;

    function automatic logic [reg_size-1:0] forward(input logic [reg_ptr_size-1:0] src,
                                                    input logic [reg_size-1:0] rf_val);
        if (xm_fwd && insn_dst(xm) == src)
            return xm_o;
        if (writes_reg(mw) && insn_dst(mw) == src)
            return w_result;
        return rf_val;
    endfunction

    always_comb
    begin
        a_fwd = forward(dx.src_0, dx_a);
        b_fwd = forward(dx.src_1, dx_b);
        c_fwd = forward(dx.src_2, dx_c);
    end

    // store data from a load that is now in writeback
    assign m_c = (mw.opc == op_ld && insn_dst(mw) == xm.src_2) ? mw_d : xm_c;

    always_comb
    begin
        if (is_mem(dx))
            x_o = a_fwd;  // address offset
        else if (dx.opc == op_set_const)
            x_o = (dx.src_0 == '0) ? reg_size'(core_id) : insn_const(dx);
        else
            x_o = alu_result;
    end

    assign fd_reads_ab = fd.opc inside {[op_add:op_xor], op_ld, op_st};
    assign fd_reads_a  = fd_reads_ab || is_branch(fd);
    assign stall = dx.opc == op_ld
                   && ((fd_reads_a && fd.src_0 == insn_dst(dx))
                       || (fd_reads_ab && fd.src_1 == insn_dst(dx)));
    assign taken = is_branch(dx) && nonzero;
    assign fetch_stop = fd.opc == op_ready || dx.opc == op_ready
                        || xm.opc == op_ready || mw.opc == op_ready;  // drain after READY
    assign freeze = is_mem(xm) && !mem_rsp.ready;
    assign hold   = ready || freeze;

    always_comb
    begin
        if (xm.opc == op_ld)
            mem_req.op = mem_read;
        else if (xm.opc == op_st)
            mem_req.op = mem_write;
        else
            mem_req.op = mem_idle;
        mem_req.addr    = {xm_b[core_id_size-1:0], xm_o};
        mem_req.wr_data = m_c;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ready <= 1'b1;
            pc    <= '0;
            fd    <= nop_insn;
            dx    <= nop_insn;
            xm    <= nop_insn;
            mw    <= nop_insn;
        end
        else if (accept)
        begin
            ready <= 1'b0;
            pc    <= '0;
        end
        else if (!hold)
        begin
            if (mw.opc == op_ready)
                ready <= 1'b1;
            mw <= xm;
            xm <= dx;
            dx <= (stall || taken) ? nop_insn : fd;
            if (taken)
                fd <= nop_insn;  // second flushed slot
            else if (!stall)
                fd <= fetch_stop ? nop_insn : fetched;
            if (taken)
                pc <= insn_target(dx);
            else if (!(stall || fetch_stop))
                pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!hold)
        begin
            dx_a <= rd_0;
            dx_b <= rd_1;
            dx_c <= rd_2;
            xm_o <= x_o;
            xm_b <= b_fwd;
            xm_c <= c_fwd;
            mw_o <= xm_o;
            mw_d <= mem_rsp.rd_data;  // valid when a load leaves memory
        end
    end

    assert property (@(posedge clk) disable iff (reset) ready |-> mem_req.op == mem_idle)
        else $error("core %0d: memory request while ready", core_id);

endmodule

`default_nettype wire

// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int reg_size      = 8;
    localparam int reg_ptr_size  = 4;
    localparam int reg_count     = 16;
    localparam int insn_size     = 16;
    localparam int insn_ptr_size = 8;
    localparam int core_id_size  = 1;
    localparam int addr_size     = reg_size + core_id_size;  // core id bits sit above the offset

    typedef enum logic [3:0] {
        op_nop, op_add, op_sub, op_mul, op_cmpge, op_rshift, op_lshift, op_and,
        op_or, op_xor, op_ld, op_st, op_set_const, op_bnz, op_ready
    } opcode_t;

    typedef struct packed {
        opcode_t                 opc;
        logic [reg_ptr_size-1:0] src_0;
        logic [reg_ptr_size-1:0] src_1;
        logic [reg_ptr_size-1:0] src_2;  // also dst for reg-reg ops and ld
    } insn_t;

    localparam insn_t nop_insn   = '{op_nop, 4'h0, 4'h0, 4'h0};
    localparam insn_t ready_insn = '{op_ready, 4'h0, 4'h0, 4'h0};

    typedef enum logic [1:0] {mem_idle, mem_read, mem_write} mem_op_t;

    typedef struct packed {
        mem_op_t              op;
        logic [addr_size-1:0] addr;
        logic [reg_size-1:0]  wr_data;
    } mem_req_t;

    typedef struct packed {
        logic                ready;  // one-cycle pulse
        logic [reg_size-1:0] rd_data;
    } mem_rsp_t;

    function automatic logic [reg_ptr_size-1:0] insn_dst(input insn_t i);
        return (i.opc == op_set_const) ? i.src_0 : i.src_2;
    endfunction

    function automatic logic [reg_size-1:0] insn_const(input insn_t i);
        return {i.src_1, i.src_2};
    endfunction

    function automatic logic [insn_ptr_size-1:0] insn_target(input insn_t i);
        return {i.src_0, i.src_1};  // bits 11 to 4
    endfunction

    function automatic logic writes_reg(input insn_t i);
        return i.opc inside {[op_add:op_xor], op_ld, op_set_const};
    endfunction

    function automatic logic is_mem(input insn_t i);
        return i.opc inside {op_ld, op_st};
    endfunction

    function automatic logic is_branch(input insn_t i);
        return i.opc == op_bnz;
    endfunction

endpackage

`default_nettype wire

// ==== data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory
    import core_pkg::*;
(
    input  logic                 clk,
    input  logic                 en,
    input  logic                 we,
    input  logic [addr_size-1:0] addr,
    input  logic [reg_size-1:0]  wdata,
    output logic [reg_size-1:0]  rdata
);

    localparam int depth = 1 << addr_size;

    logic [reg_size-1:0] mem [depth];

    always_ff @(posedge clk)
    begin
        if (en)
        begin
            if (we)
                mem[addr] <= wdata;
            rdata <= mem[addr];  // old data on a write
        end
    end

    assert property (@(posedge clk) en |-> !$isunknown(addr))
        else $error("data memory address unknown while enabled");

    assert property (@(posedge clk) en |-> !$isunknown(we))
        else $error("data memory write enable unknown while enabled");

endmodule

`default_nettype wire

// ==== insn_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_memory
    import core_pkg::*;
#(
    parameter int insn_count = 16
)(
    input  logic                            clk,
    input  logic                            load,
    input  logic [insn_count*insn_size-1:0] insn_data,
    input  logic [insn_ptr_size-1:0]        ptr,
    output insn_t                           insn
);

    localparam int idx_w = (insn_count > 1) ? $clog2(insn_count) : 1;

    insn_t mem [insn_count];

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            for (int i = 0; i < insn_count; i++)
                mem[i] <= insn_t'(insn_data[i*insn_size +: insn_size]);  // insn 0 in the low bits
        end
    end

    // past the end of the program reads as READY
    assign insn = (int'(ptr) < insn_count) ? mem[ptr[idx_w-1:0]] : ready_insn;

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import core_pkg::*;
#(
    parameter int num_ports = 3
)(
    input  logic                 clk,
    input  logic                 reset,
    input  mem_req_t             req [num_ports],
    output mem_rsp_t             rsp [num_ports],
    output logic                 mem_en,
    output logic                 mem_we,
    output logic [addr_size-1:0] mem_addr,
    output logic [reg_size-1:0]  mem_wdata,
    input  logic [reg_size-1:0]  mem_rdata
);

    localparam int idx_w = (num_ports > 1) ? $clog2(num_ports) : 1;

    logic busy, pulse, found;
    logic [idx_w-1:0] last, pick;  // last is also the port being served

    always_comb
    begin
        logic [idx_w-1:0] cand;
        found = 1'b0;
        pick  = last;
        for (int k = 1; k <= num_ports; k++)
        begin
            cand = idx_w'((int'(last) + k) % num_ports);
            // port in its ready cycle still shows the old request
            if (!found && req[cand].op != mem_idle && !(pulse && cand == last))
            begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy  <= 1'b0;
            pulse <= 1'b0;
            last  <= idx_w'(num_ports - 1);  // port 0 first
        end
        else
        begin
            pulse <= busy;
            if (busy)
                busy <= 1'b0;
            else if (found)
            begin
                busy <= 1'b1;
                last <= pick;
            end
        end
    end

    assign mem_en    = busy;
    assign mem_we    = busy && req[last].op == mem_write;
    assign mem_addr  = req[last].addr;
    assign mem_wdata = req[last].wr_data;

    for (genvar i = 0; i < num_ports; i++)
    begin : g_rsp
        assign rsp[i] = '{ready: pulse && last == idx_w'(i), rd_data: mem_rdata};
    end

    assert property (@(posedge clk) disable iff (reset) pulse |-> req[last].op != mem_idle)
        else $error("port %0d dropped its request before ready", last);

endmodule

`default_nettype wire

// ==== multicore_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module multicore_tb
    import core_pkg::*;
();

    localparam int num_cores  = 2;
    localparam int insn_count = 16;
    localparam int test_cycles [5] = '{250, 120, 120, 150, 120};  // expected cycles per test
    localparam opcode_t alu_ops [12] = '{op_add, op_sub, op_mul, op_cmpge, op_rshift, op_lshift,
                                        op_and, op_or, op_xor, op_mul, op_sub, op_add};

    logic clk, reset;
    logic [num_cores-1:0] start, init_r0_flag, ready;
    logic [reg_size-1:0] init_r0_data [num_cores];
    logic [insn_count*insn_size-1:0] insn_data [num_cores];
    mem_req_t host_req;
    mem_rsp_t host_rsp;

    integer seed = 32'h3c162355;
    int error_count = 0;
    int timeout_count = 0;
    int host_count = 0;
    int host_wait;
    logic check_rd;
    logic [addr_size-1:0] exp_addr;
    logic [reg_size-1:0] exp_rdata;
    logic [reg_size-1:0] model_mem [1 << addr_size];
    logic [addr_size-1:0] check_addrs [$];
    insn_t prog [insn_count];
    int prog_len;

    tb_clock #(.period(100)) tb_clock_i (.clk(clk));

    multicore_top #(
        .num_cores(num_cores),
        .insn_count(insn_count)
    ) multicore_top_i (
        .clk(clk),
        .reset(reset),
        .start(start),
        .init_r0_flag(init_r0_flag),
        .init_r0_data(init_r0_data),
        .insn_data(insn_data),
        .ready(ready),
        .host_req(host_req),
        .host_rsp(host_rsp)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
            host_wait <= 0;
        else if (host_req.op != mem_idle && !host_rsp.ready)
            host_wait <= host_wait + 1;  // cycles since the host raised its request
        else
            host_wait <= 0;
    end

    assert property (@(posedge clk) disable iff (reset)
                     check_rd && host_rsp.ready |-> host_rsp.rd_data == exp_rdata)
    else
    begin
        error_count++;
        $display("[ERROR] host_rsp.rd_data at %h: expected %h actual %h",
                 exp_addr, exp_rdata, host_rsp.rd_data);
    end

    assert property (@(posedge clk) disable iff (reset) host_wait <= 6)
    else
    begin
        error_count++;
        $display("host request waited more than 6 cycles for its ready pulse");
    end

    for (genvar c = 0; c < num_cores; c++)
    begin : g_ready_check
        assert property (@(posedge clk) disable iff (reset) start[c] && ready[c] |=> !ready[c])
        else
        begin
            error_count++;
            $display("[ERROR] ready[%0d]: expected %h actual %h", c, 1'b0, 1'b1);
        end
    end

    function automatic logic [reg_size-1:0] random_byte();
        return reg_size'($random(seed));
    endfunction

    // reference results straight from the opcode descriptions
    function automatic logic [reg_size-1:0] alu_ref(input opcode_t opc,
                                                    input logic [reg_size-1:0] a,
                                                    input logic [reg_size-1:0] b);
        int x, y, r;
        x = int'(a);
        y = int'(b);
        case (opc)
            op_add:    r = x + y;
            op_sub:    r = x - y + 256;
            op_mul:    r = x * y;
            op_cmpge:  r = (x >= y) ? 1 : 0;
            op_rshift: r = x / (1 << (y % 8));
            op_lshift: r = x * (1 << (y % 8));
            op_and:    r = x & y;
            op_or:     r = x | y;
            op_xor:    r = x ^ y;
            default:   r = 0;
        endcase
        return reg_size'(r & 255);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_program();
        foreach (prog[i])
            prog[i] = nop_insn;
        prog_len = 0;
    endtask

    task automatic emit(input opcode_t opc, input int s0, input int s1, input int s2);
        prog[prog_len] = '{opc, 4'(s0), 4'(s1), 4'(s2)};
        prog_len++;
    endtask

    task automatic emit_const(input int dst, input logic [reg_size-1:0] value);
        emit(op_set_const, dst, int'(value[7:4]), int'(value[3:0]));
    endtask

    task automatic load_program(input int core);
        for (int i = 0; i < insn_count; i++)
            insn_data[core][i*insn_size +: insn_size] = prog[i];
    endtask

    task automatic expect_byte(input logic [addr_size-1:0] addr, input logic [reg_size-1:0] value);
        model_mem[addr] = value;
        check_addrs.push_back(addr);
    endtask

    task automatic host_access(input mem_op_t op, input logic [addr_size-1:0] addr,
                               input logic [reg_size-1:0] data, input logic check);
        int cycles;
        host_req = '{op: op, addr: addr, wr_data: data};
        check_rd = check;
        exp_addr = addr;
        exp_rdata = model_mem[addr];
        cycles = 0;
        do
        begin
            next_cycle();
            cycles++;
        end
        while (!host_rsp.ready && cycles < 20);
        if (!host_rsp.ready)
        begin
            timeout_count++;
            $display("host access to address %h got no ready pulse", addr);
        end
        next_cycle();  // request stays up through the ready cycle
        host_req.op = mem_idle;
        check_rd = 1'b0;
        host_count++;
    endtask

    task automatic host_write(input logic [addr_size-1:0] addr, input logic [reg_size-1:0] data);
        model_mem[addr] = data;
        host_access(mem_write, addr, data, 1'b0);
    endtask

    task automatic verify_stores();
        logic [addr_size-1:0] a;
        while (check_addrs.size() > 0)
        begin
            a = check_addrs.pop_front();
            host_access(mem_read, a, '0, 1'b1);
        end
    endtask

    task automatic run_cores(input logic [num_cores-1:0] mask, input logic init_flag,
                             input logic [reg_size-1:0] init_data);
        start = mask;
        init_r0_flag = init_flag ? mask : '0;
        for (int c = 0; c < num_cores; c++)
            init_r0_data[c] = init_data;
        next_cycle();
        start = '0;
        init_r0_flag = '0;
    endtask

    task automatic wait_ready(input int core);
        int cycles;
        cycles = 0;
        while (!ready[core] && cycles < 400)
        begin
            next_cycle();
            cycles++;
        end
        if (!ready[core])
        begin
            timeout_count++;
            $display("core %0d did not raise ready within %0d cycles", core, cycles);
        end
    endtask

    task automatic report_counts();
        $display("errors %0d, timeouts %0d, host accesses %0d",
                 error_count, timeout_count, host_count);
    endtask

    task automatic test_alu();
        logic [reg_size-1:0] x, y, acc;
        logic [reg_size-1:0] res [4];
        opcode_t opc;
        for (int run = 0; run < 3; run++)
        begin
            x = random_byte();
            y = random_byte();
            clear_program();
            emit_const(1, x);
            emit_const(2, y);
            emit_const(0, 8'hff);  // lands as core id 0
            for (int k = 0; k < 4; k++)
            begin
                opc = alu_ops[4 * run + k];
                emit(opc, (k == 0) ? 1 : 2 + k, (k == 0) ? 2 : 1, 3 + k);
                acc = (k == 0) ? alu_ref(opc, x, y) : alu_ref(opc, acc, x);
                res[k] = acc;
            end
            for (int k = 0; k < 4; k++)
            begin
                emit_const(8 + k, 8'(16 * run + k));
                emit(op_st, 8 + k, 0, 3 + k);
                expect_byte({1'b0, 8'(16 * run + k)}, res[k]);
            end
            load_program(0);
            run_cores(2'b01, 1'b0, '0);
            wait_ready(0);
            verify_stores();
        end
    endtask

    task automatic test_load_use();
        logic [reg_size-1:0] b0, b1;
        b0 = random_byte();
        b1 = random_byte();
        host_write({1'b1, 8'h20}, b0);
        host_write({1'b1, 8'h21}, b1);
        clear_program();
        emit_const(0, 8'h00);  // core 1 gets r0 = 1, upper half
        emit_const(1, 8'h20);
        emit_const(4, 8'h21);
        emit_const(7, 8'h30);
        emit(op_ld, 1, 0, 2);
        emit(op_add, 2, 2, 3);  // load-use
        emit(op_ld, 4, 0, 5);
        emit(op_add, 5, 3, 6);
        emit(op_ld, 4, 0, 8);
        emit(op_st, 7, 0, 8);   // data from the load in writeback
        emit_const(9, 8'h31);
        emit(op_st, 9, 0, 6);
        emit(op_ld, 1, 0, 10);
        emit(op_add, 10, 6, 11);
        emit_const(12, 8'h32);
        emit(op_st, 12, 0, 11);
        load_program(1);
        run_cores(2'b10, 1'b0, '0);
        wait_ready(1);
        expect_byte({1'b1, 8'h30}, b1);
        expect_byte({1'b1, 8'h31}, 8'(b1 + 2 * b0));
        expect_byte({1'b1, 8'h32}, 8'(3 * b0 + b1));
        verify_stores();
    endtask

    task automatic test_branch();
        int count;
        logic [reg_size-1:0] step;
        count = 1 + $unsigned($random(seed)) % 20;
        step = random_byte();
        clear_program();
        emit_const(1, 8'(count));
        emit_const(2, step);
        emit_const(3, step);    // one step too many, taken back after the loop
        emit_const(4, 8'h01);
        emit(op_or, 1, 1, 0);   // r0 is the loop counter
        emit(op_add, 3, 2, 3);
        emit(op_sub, 0, 4, 0);
        emit(op_bnz, 0, 5, 0);  // back to 5 while r0 is nonzero
        emit(op_sub, 3, 2, 3);  // runs once only if the flush works
        emit_const(6, 8'h40);
        emit(op_st, 6, 0, 3);
        load_program(0);
        run_cores(2'b01, 1'b0, '0);
        wait_ready(0);
        expect_byte({1'b0, 8'h40}, 8'(count * step));
        verify_stores();
    endtask

    task automatic test_contention();
        logic [reg_size-1:0] v, inc;
        int polls;
        for (int c = 0; c < num_cores; c++)
        begin
            v = random_byte();
            inc = random_byte();
            clear_program();
            emit_const(0, 8'h00);
            emit_const(1, v);
            emit_const(3, inc);
            for (int k = 0; k < 4; k++)
            begin
                emit_const(4 + k, 8'(8'h50 + k));
                emit(op_st, 4 + k, 0, 1);
                emit(op_add, 1, 3, 1);
                expect_byte({1'(c), 8'(8'h50 + k)}, 8'(v + k * inc));
            end
            load_program(c);
        end
        run_cores('1, 1'b0, '0);
        polls = 0;
        while (ready != '1 && polls < 100)
        begin
            host_access(mem_read, 9'($random(seed)), '0, 1'b0);  // latency check only
            polls++;
        end
        for (int c = 0; c < num_cores; c++)
            wait_ready(c);
        verify_stores();
    endtask

    task automatic test_restart();
        logic [reg_size-1:0] k, d;
        k = random_byte();
        clear_program();
        emit_const(1, k);
        emit(op_add, 0, 1, 2);
        emit_const(3, 8'h60);
        emit_const(4, 8'h01);
        emit(op_st, 3, 4, 2);
        load_program(1);
        for (int run = 0; run < 2; run++)
        begin
            d = random_byte();
            run_cores(2'b10, 1'b1, d);
            wait_ready(1);
            expect_byte({1'b1, 8'h60}, 8'(d + k));
            verify_stores();
        end
    endtask

    initial
    begin : watchdog
        int limit;
        limit = 4;
        foreach (test_cycles[i])
            limit += test_cycles[i] + 100;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles", limit);
        report_counts();
        $display("Test failed");
        $finish;
    end

    initial
    begin : main
        reset = 1'b1;
        start = '0;
        init_r0_flag = '0;
        init_r0_data = '{default: '0};
        insn_data = '{default: '0};
        host_req = '{op: mem_idle, addr: '0, wr_data: '0};
        check_rd = 1'b0;
        exp_addr = '0;
        exp_rdata = '0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        test_alu();
        test_load_use();
        test_branch();
        test_contention();
        test_restart();
        next_cycle();
        report_counts();
        if (error_count == 0 && timeout_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== multicore_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module multicore_top
    import core_pkg::*;
#(
    parameter int num_cores  = 2,
    parameter int insn_count = 16
)(
    input  logic                            clk,
    input  logic                            reset,
    input  logic [num_cores-1:0]            start,
    input  logic [num_cores-1:0]            init_r0_flag,
    input  logic [reg_size-1:0]             init_r0_data [num_cores],
    input  logic [insn_count*insn_size-1:0] insn_data [num_cores],
    output logic [num_cores-1:0]            ready,
    input  mem_req_t                        host_req,
    output mem_rsp_t                        host_rsp
);

    mem_req_t req_bus [num_cores+1];  // cores first, host last
    mem_rsp_t rsp_bus [num_cores+1];
    logic mem_en, mem_we;
    logic [addr_size-1:0] mem_addr;
    logic [reg_size-1:0] mem_wdata, mem_rdata;

    for (genvar i = 0; i < num_cores; i++)
    begin : g_core
        core #(
            .core_id(i),
            .insn_count(insn_count)
        ) core_i (
            .clk(clk),
            .reset(reset),
            .start(start[i]),
            .init_r0_flag(init_r0_flag[i]),
            .init_r0_data(init_r0_data[i]),
            .insn_data(insn_data[i]),
            .ready(ready[i]),
            .mem_req(req_bus[i]),
            .mem_rsp(rsp_bus[i])
        );
    end

    assign req_bus[num_cores] = host_req;
    assign host_rsp = rsp_bus[num_cores];

    mem_arbiter #(.num_ports(num_cores + 1)) mem_arbiter_i (
        .clk(clk),
        .reset(reset),
        .req(req_bus),
        .rsp(rsp_bus),
        .mem_en(mem_en),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    data_memory data_memory_i (
        .clk(clk),
        .en(mem_en),
        .we(mem_we),
        .addr(mem_addr),
        .wdata(mem_wdata),
        .rdata(mem_rdata)
    );

endmodule

`default_nettype wire

// ==== register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file
    import core_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    init_r0,
    input  logic [reg_size-1:0]     init_r0_data,
    input  logic [reg_ptr_size-1:0] src_0,
    input  logic [reg_ptr_size-1:0] src_1,
    input  logic [reg_ptr_size-1:0] src_2,
    output logic [reg_size-1:0]     rd_0,
    output logic [reg_size-1:0]     rd_1,
    output logic [reg_size-1:0]     rd_2,
    input  logic                    wr_en,
    input  logic [reg_ptr_size-1:0] wr_addr,
    input  logic [reg_size-1:0]     wr_data
);

    logic [reg_size-1:0] regs [reg_count];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < reg_count; i++)
                regs[i] <= '0;
        end
        else
        begin
            if (wr_en)
                regs[wr_addr] <= wr_data;
            if (init_r0)
                regs[0] <= init_r0_data;  // start wins over writeback
        end
    end

    // writeback result is seen by decode in the same cycle
    assign rd_0 = (wr_en && wr_addr == src_0) ? wr_data : regs[src_0];
    assign rd_1 = (wr_en && wr_addr == src_1) ? wr_data : regs[src_1];
    assign rd_2 = (wr_en && wr_addr == src_2) ? wr_data : regs[src_2];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module multicore_tb -f sim.f \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vmulticore_tb > sim.log 2>&1
cat sim.log
grep -qx "Test passed" sim.log && exit 0 || exit 1

// ==== sim.f ====
core_pkg.sv
register_file.sv
alu.sv
insn_memory.sv
core.sv
mem_arbiter.sv
data_memory.sv
multicore_top.sv
tb_clock.sv
multicore_tb.sv

// ==== tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period = 100
)(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period / 2) clk = ~clk;
    end

endmodule

`default_nettype wire
